//--- aluResStation.f
verilog/rsPkg.sv
verilog/rsQueuePtrs.sv
verilog/rsWakeupMatch.sv
verilog/rsEntryArray.sv
verilog/rsIssueSelect.sv
verilog/aluResStation.sv
tb/aluResStation_assertions.sv
tb/aluResStationTb.sv

//--- Bender.yml
package:
  name: aluResStation

sources:
  - verilog/rsPkg.sv
  - verilog/rsQueuePtrs.sv
  - verilog/rsWakeupMatch.sv
  - verilog/rsEntryArray.sv
  - verilog/rsIssueSelect.sv
  - verilog/aluResStation.sv
  - target: test
    files:
      - tb/aluResStation_assertions.sv
      - tb/aluResStationTb.sv

//--- tb/aluResStationTb.sv
module aluResStationTb;
    import rsPkg::*;

    localparam int waitLimit = 200;   // cycles any single wait may take

    logic    clk;
    logic    rstN;
    logic    exception;
    logic    allocValid;
    rsAllocT alloc;
    logic    allocReady;
    bcastT   bcast [numBcast];
    logic    issueValid;
    rsOpT    issueOp;
    logic    issueReady;

    integer seed = 32'h9cf4;
    int     errors;
    int     testsPassed;
    int     testsFailed;
    int     nextInst;

    // scoreboard in allocation order
    rsOpT sbOp [$];
    bit   sbIssued [$];
    bit   sbFlushed [$];
    int   issueLog [$];   // scoreboard indices in issue order

    aluResStation dut0 (
        .clk        (clk),
        .rstN       (rstN),
        .exception  (exception),
        .allocValid (allocValid),
        .alloc      (alloc),
        .allocReady (allocReady),
        .bcast      (bcast),
        .issueValid (issueValid),
        .issueOp    (issueOp),
        .issueReady (issueReady)
    );

    always #10 clk = ~clk;

    function automatic int totalErrors();
        return errors + dut0.chk0.failCount;
    endfunction

    task automatic valueError(input string sig, input logic [127:0] expected,
                              input logic [127:0] actual);
        $display("FAILED time=%0t signal=%s expected=%0h actual=%0h",
                 $time, sig, expected, actual);
        errors++;
    endtask

    task automatic plainError(input string msg);
        $display("FAILED at time %0t: %s", $time, msg);
        errors++;
    endtask

    task automatic nextCycle();
        @(posedge clk);
        #2;
    endtask

    // stays below the tags reserved for waiting sources
    function automatic logic [tagWidth-1:0] randTag();
        logic [31:0] r;
        r = $random(seed);
        return {1'b0, r[tagWidth-2:0]};
    endfunction

    function automatic rsOpT makeOp(input logic [tagWidth-1:0] s1,
                                    input logic [tagWidth-1:0] s2);
        rsOpT        op;
        logic [31:0] r;
        r           = $random(seed);
        op.instNum  = nextInst;
        op.rd       = r[tagWidth-1:0];
        op.memToReg = r[8];
        op.memRead  = r[9];
        op.memWrite = r[10];
        op.aluSrc2  = r[11];
        op.aluOp    = aluOpT'(r[15:12] % 4'd10);
        op.funct3   = r[18:16];
        op.imm      = $random(seed);
        op.src1     = s1;
        op.src2     = s2;
        nextInst++;
        return op;
    endfunction

    function automatic int findInst(input logic [31:0] inst);
        foreach (sbOp[i]) begin
            if (sbOp[i].instNum == inst) begin
                return i;
            end
        end
        return -1;
    endfunction

    function automatic int issuePos(input int idx);
        foreach (issueLog[i]) begin
            if (issueLog[i] == idx) begin
                return i;
            end
        end
        return -1;
    endfunction

    task automatic checkIssue(input rsOpT got);
        int idx;
        idx = findInst(got.instNum);
        if (idx < 0) begin
            plainError($sformatf("issued instNum %0d was never accepted", got.instNum));
        end else if (sbFlushed[idx]) begin
            plainError($sformatf("flushed instNum %0d issued", got.instNum));
        end else if (sbIssued[idx]) begin
            plainError($sformatf("instNum %0d issued twice", got.instNum));
        end else begin
            if (got !== sbOp[idx]) begin
                valueError("issueOp", sbOp[idx], got);
            end
            sbIssued[idx] = 1'b1;
            issueLog.push_back(idx);
        end
    endtask

    // transfers happen on edges where both valid and ready are high
    always @(posedge clk) begin
        if (rstN && issueValid && issueReady) begin
            checkIssue(issueOp);
        end
    end

    task automatic allocate(input rsOpT op, input logic r1, input logic r2,
                            input logic bcValid, input logic [tagWidth-1:0] bcTag,
                            input int bus, output int idx);
        int waited;
        waited          = 0;
        idx             = -1;
        allocValid      = 1'b1;
        alloc.op        = op;
        alloc.src1Ready = r1;
        alloc.src2Ready = r2;
        while (!allocReady && waited < waitLimit) begin
            nextCycle();
            waited++;
        end
        if (!allocReady) begin
            plainError($sformatf("allocReady never rose for instNum %0d", op.instNum));
        end else begin
            bcast[bus].valid = bcValid;   // same-cycle wakeup when set
            bcast[bus].tag   = bcTag;
            nextCycle();
            sbOp.push_back(op);
            sbIssued.push_back(1'b0);
            sbFlushed.push_back(1'b0);
            idx = sbOp.size() - 1;
        end
        allocValid = 1'b0;
        bcast[bus] = '0;
    endtask

    task automatic allocPlain(input rsOpT op, input logic r1, input logic r2, output int idx);
        allocate(op, r1, r2, 1'b0, '0, 0, idx);
    endtask

    task automatic broadcastTag(input logic [tagWidth-1:0] tag, input int bus);
        bcast[bus].valid = 1'b1;
        bcast[bus].tag   = tag;
        nextCycle();
        bcast[bus] = '0;
    endtask

    task automatic waitIssued(input int idx);
        int waited;
        waited = 0;
        while (idx >= 0 && !sbIssued[idx] && waited < waitLimit) begin
            nextCycle();
            waited++;
        end
        if (idx >= 0 && !sbIssued[idx]) begin
            plainError($sformatf("timed out waiting for instNum %0d to issue",
                                 sbOp[idx].instNum));
        end
    endtask

    task automatic waitIssueValid();
        int waited;
        waited = 0;
        while (issueValid !== 1'b1 && waited < waitLimit) begin
            nextCycle();
            waited++;
        end
        if (issueValid !== 1'b1) begin
            plainError("timed out waiting for issueValid");
        end
    endtask

    task automatic finishTest(input string name, input int startErr);
        if (totalErrors() == startErr) begin
            $display("test %s: ok", name);
            testsPassed++;
        end else begin
            $display("test %s: %0d error(s)", name, totalErrors() - startErr);
            testsFailed++;
        end
    endtask

    task automatic inOrderIssue();
        int startErr;
        int ids [6];
        startErr   = totalErrors();
        issueReady = 1'b1;
        for (int i = 0; i < 6; i++) begin
            allocPlain(makeOp(randTag(), randTag()), 1'b1, 1'b1, ids[i]);
        end
        for (int i = 0; i < 6; i++) begin
            waitIssued(ids[i]);
        end
        for (int i = 1; i < 6; i++) begin
            if (issuePos(ids[i]) < issuePos(ids[i-1])) begin
                plainError($sformatf("instNum %0d issued ahead of older instNum %0d",
                                     sbOp[ids[i]].instNum, sbOp[ids[i-1]].instNum));
            end
        end
        finishTest("inOrder", startErr);
    endtask

    task automatic tagWakeup();
        int startErr;
        int ids [numBcast];
        int idY;
        startErr   = totalErrors();
        issueReady = 1'b1;
        for (int b = 0; b < numBcast; b++) begin
            allocPlain(makeOp(randTag(), tagWidth'(8'hA0 + b)), 1'b1, 1'b0, ids[b]);
        end
        allocPlain(makeOp(randTag(), randTag()), 1'b1, 1'b1, idY);
        waitIssued(idY);   // younger but ready, goes first
        for (int b = 0; b < numBcast; b++) begin
            if (sbIssued[ids[b]]) begin
                plainError($sformatf("instNum %0d issued before its tag was broadcast",
                                     sbOp[ids[b]].instNum));
            end
            broadcastTag(tagWidth'(8'hA0 + b), b);   // one bus per waiter
            waitIssued(ids[b]);
        end
        finishTest("wakeup", startErr);
    endtask

    task automatic sameCycleWakeup();
        int startErr;
        int idA;
        startErr   = totalErrors();
        issueReady = 1'b1;
        allocate(makeOp(8'hB0, randTag()), 1'b0, 1'b1, 1'b1, 8'hB0, 1, idA);
        waitIssued(idA);
        finishTest("allocWake", startErr);
    endtask

    task automatic fillThenDrain();
        int startErr;
        int ids [rsDepth];
        startErr   = totalErrors();
        issueReady = 1'b0;
        for (int i = 0; i < rsDepth; i++) begin
            allocPlain(makeOp(tagWidth'(8'hC0 + i), randTag()), 1'b0, 1'b1, ids[i]);
        end
        // one more request, never recorded, so acceptance shows up as an unknown issue
        alloc.op        = makeOp(randTag(), randTag());
        alloc.src1Ready = 1'b1;
        alloc.src2Ready = 1'b1;
        allocValid      = 1'b1;
        for (int c = 0; c < 3; c++) begin
            if (allocReady !== 1'b0) begin
                valueError("allocReady", 1'b0, allocReady);
            end
            nextCycle();
        end
        allocValid = 1'b0;
        issueReady = 1'b1;
        for (int i = 0; i < rsDepth; i += numBcast) begin
            for (int b = 0; b < numBcast; b++) begin
                bcast[b].valid = 1'b1;
                bcast[b].tag   = tagWidth'(8'hC0 + i + b);
            end
            nextCycle();
        end
        for (int b = 0; b < numBcast; b++) begin
            bcast[b] = '0;
        end
        for (int i = 0; i < rsDepth; i++) begin
            waitIssued(ids[i]);
        end
        finishTest("full", startErr);
    endtask

    task automatic holdUnderStall();
        int   startErr;
        int   idP;
        int   idQ;
        int   logStart;
        rsOpT held;
        startErr   = totalErrors();
        issueReady = 1'b0;
        allocPlain(makeOp(randTag(), randTag()), 1'b1, 1'b1, idP);
        allocPlain(makeOp(randTag(), randTag()), 1'b1, 1'b1, idQ);
        waitIssueValid();
        held = issueOp;
        if (held !== sbOp[idP]) begin
            valueError("issueOp", sbOp[idP], held);
        end
        for (int c = 0; c < 5; c++) begin
            nextCycle();
            if (issueValid !== 1'b1) begin
                valueError("issueValid", 1'b1, issueValid);
            end
            if (issueOp !== held) begin
                valueError("issueOp", held, issueOp);
            end
        end
        logStart   = issueLog.size();
        issueReady = 1'b1;
        waitIssued(idP);
        waitIssued(idQ);
        if (issueLog.size() > logStart && issueLog[logStart] != idP) begin
            plainError("the operation held during the stall was not delivered first");
        end
        finishTest("stall", startErr);
    endtask

    task automatic flushPending();
        int startErr;
        int ids [5];
        int idN [2];
        startErr   = totalErrors();
        issueReady = 1'b0;
        for (int i = 0; i < 3; i++) begin
            allocPlain(makeOp(randTag(), randTag()), 1'b1, 1'b1, ids[i]);
        end
        for (int i = 3; i < 5; i++) begin
            allocPlain(makeOp(8'hD0, randTag()), 1'b0, 1'b1, ids[i]);
        end
        waitIssueValid();
        exception = 1'b1;
        nextCycle();
        exception = 1'b0;
        for (int i = 0; i < sbOp.size(); i++) begin
            if (!sbIssued[i]) begin
                sbFlushed[i] = 1'b1;
            end
        end
        if (allocReady !== 1'b1) begin
            valueError("allocReady", 1'b1, allocReady);
        end
        if (issueValid !== 1'b0) begin
            valueError("issueValid", 1'b0, issueValid);
        end
        issueReady = 1'b1;
        broadcastTag(8'hD0, 0);   // flushed waiters must stay gone
        for (int i = 0; i < 2; i++) begin
            allocPlain(makeOp(randTag(), randTag()), 1'b1, 1'b1, idN[i]);
        end
        waitIssued(idN[0]);
        waitIssued(idN[1]);
        repeat (4) nextCycle();
        finishTest("flush", startErr);
    endtask

    initial begin
        clk         = 1'b0;
        rstN        = 1'b0;
        exception   = 1'b0;
        allocValid  = 1'b0;
        alloc       = '0;
        issueReady  = 1'b0;
        errors      = 0;
        testsPassed = 0;
        testsFailed = 0;
        nextInst    = 1;
        for (int b = 0; b < numBcast; b++) begin
            bcast[b] = '0;
        end
        repeat (2) @(posedge clk);
        #2;
        rstN = 1'b1;
        if (issueValid !== 1'b0) begin
            valueError("issueValid", 1'b0, issueValid);
        end
        if (allocReady !== 1'b1) begin
            valueError("allocReady", 1'b1, allocReady);
        end
        inOrderIssue();
        tagWakeup();
        sameCycleWakeup();
        fillThenDrain();
        holdUnderStall();
        flushPending();
        for (int i = 0; i < sbOp.size(); i++) begin
            if (!sbIssued[i] && !sbFlushed[i]) begin
                plainError($sformatf("instNum %0d was never issued", sbOp[i].instNum));
            end
        end
        $display("tests passed %0d, failed %0d, errors %0d",
                 testsPassed, testsFailed, totalErrors());
        if (testsFailed == 0 && totalErrors() == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

    initial begin
        repeat (5000) @(posedge clk);
        $display("run did not finish within 5000 cycles");
        $display("STATUS: FAIL");
        $finish;
    end

endmodule

//--- tb/aluResStation_assertions.sv
module aluResStationAssertions (
    input logic        clk,
    input logic        rstN,
    input logic        exception,
    input logic        allocValid,
    input logic        allocReady,
    input logic        issueValid,
    input logic        issueReady,
    input rsPkg::rsOpT issueOp
);
    import rsPkg::*;

    int failCount = 0;
    int outstanding;   // accepted and not yet transferred since the last flush

    always_ff @(posedge clk) begin
        if (!rstN || exception) begin
            outstanding <= 0;
        end else begin
            outstanding <= outstanding + int'(allocValid && allocReady)
                           - int'(issueValid && issueReady);
        end
    end

    stallHold: assert property (@(posedge clk) disable iff (!rstN)
        issueValid && !issueReady && !exception |=> issueValid && $stable(issueOp))
        else begin
            $error("issueOp or issueValid changed under back-pressure");
            failCount++;
        end

    flushClears: assert property (@(posedge clk) disable iff (!rstN)
        exception |=> !issueValid)
        else begin
            $error("issueValid high the cycle after exception");
            failCount++;
        end

    quietInReset: assert property (@(posedge clk) !rstN |=> !issueValid)
        else begin
            $error("issueValid high while in reset");
            failCount++;
        end

    fullOnlyWhenFull: assert property (@(posedge clk) disable iff (!rstN)
        !allocReady |-> outstanding >= rsDepth)
        else begin
            $error("allocReady low with fewer than rsDepth operations outstanding");
            failCount++;
        end

endmodule

bind aluResStation aluResStationAssertions chk0 (
    .clk        (clk),
    .rstN       (rstN),
    .exception  (exception),
    .allocValid (allocValid),
    .allocReady (allocReady),
    .issueValid (issueValid),
    .issueReady (issueReady),
    .issueOp    (issueOp)
);

//--- verilog/aluResStation.sv
module aluResStation (
    input  logic            clk,
    input  logic            rstN,
    input  logic            exception,
    input  logic            allocValid,
    input  rsPkg::rsAllocT  alloc,
    output logic            allocReady,
    input  rsPkg::bcastT    bcast [rsPkg::numBcast],
    output logic            issueValid,
    output rsPkg::rsOpT     issueOp,
    input  logic            issueReady
);
    import rsPkg::*;

    logic                allocFire;
    logic [idxWidth-1:0] head;
    logic [idxWidth-1:0] tail;
    logic [rsDepth-1:0]  occupiedVec;
    logic [rsDepth-1:0]  readyVec;
    logic [tagWidth-1:0] src1Tags [rsDepth];
    logic [tagWidth-1:0] src2Tags [rsDepth];
    logic [rsDepth-1:0]  wake1Vec;
    logic [rsDepth-1:0]  wake2Vec;
    logic                allocWake1;
    logic                allocWake2;
    logic                grantValid;
    logic [idxWidth-1:0] grantIdx;
    rsOpT                grantOp;

    rsQueuePtrs ptrs0 (
        .clk         (clk),
        .rstN        (rstN),
        .exception   (exception),
        .allocValid  (allocValid),
        .occupiedVec (occupiedVec),
        .allocReady  (allocReady),
        .allocFire   (allocFire),
        .head        (head),
        .tail        (tail)
    );

    rsWakeupMatch wake0 (
        .bcast      (bcast),
        .src1Tags   (src1Tags),
        .src2Tags   (src2Tags),
        .allocSrc1  (alloc.op.src1),
        .allocSrc2  (alloc.op.src2),
        .wake1Vec   (wake1Vec),
        .wake2Vec   (wake2Vec),
        .allocWake1 (allocWake1),
        .allocWake2 (allocWake2)
    );

    rsEntryArray entries0 (
        .clk         (clk),
        .rstN        (rstN),
        .exception   (exception),
        .allocFire   (allocFire),
        .tail        (tail),
        .alloc       (alloc),
        .wake1Vec    (wake1Vec),
        .wake2Vec    (wake2Vec),
        .allocWake1  (allocWake1),
        .allocWake2  (allocWake2),
        .grantValid  (grantValid),
        .grantIdx    (grantIdx),
        .src1Tags    (src1Tags),
        .src2Tags    (src2Tags),
        .occupiedVec (occupiedVec),
        .readyVec    (readyVec),
        .grantOp     (grantOp)
    );

    rsIssueSelect select0 (
        .clk        (clk),
        .rstN       (rstN),
        .exception  (exception),
        .head       (head),
        .readyVec   (readyVec),
        .grantOp    (grantOp),
        .issueReady (issueReady),
        .grantValid (grantValid),
        .grantIdx   (grantIdx),
        .issueValid (issueValid),
        .issueOp    (issueOp)
    );

endmodule

//--- verilog/rsIssueSelect.sv
module rsIssueSelect (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        exception,
    input  logic [rsPkg::idxWidth-1:0]  head,
    input  logic [rsPkg::rsDepth-1:0]   readyVec,
    input  rsPkg::rsOpT                 grantOp,
    input  logic                        issueReady,
    output logic                        grantValid,
    output logic [rsPkg::idxWidth-1:0]  grantIdx,
    output logic                        issueValid,
    output rsPkg::rsOpT                 issueOp
);
    import rsPkg::*;

    logic                found;
    logic [idxWidth-1:0] pickIdx;
    logic [idxWidth-1:0] scanIdx;
    logic                canLoad;

    // walk from the far end of the window back to head, the oldest hit wins
    always_comb begin
        found   = 1'b0;
        pickIdx = head;
        scanIdx = head;
        for (int k = scanWindow - 1; k >= 0; k--) begin
            scanIdx = head + idxWidth'(k);   // wraps with the ring
            if (readyVec[scanIdx]) begin
                found   = 1'b1;
                pickIdx = scanIdx;
            end
        end
    end

    assign canLoad    = !issueValid || issueReady;   // output empty or draining
    assign grantValid = found && canLoad;
    assign grantIdx   = pickIdx;

    always_ff @(posedge clk) begin
        if (!rstN || exception) begin
            issueValid <= 1'b0;
        end else if (canLoad) begin
            issueValid <= found;
        end
    end

    // held under back-pressure since no grant is made then
    always_ff @(posedge clk) begin
        if (grantValid) begin
            issueOp <= grantOp;
        end
    end

endmodule

//--- verilog/rsEntryArray.sv
module rsEntryArray (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        exception,
    input  logic                        allocFire,
    input  logic [rsPkg::idxWidth-1:0]  tail,
    input  rsPkg::rsAllocT              alloc,
    input  logic [rsPkg::rsDepth-1:0]   wake1Vec,
    input  logic [rsPkg::rsDepth-1:0]   wake2Vec,
    input  logic                        allocWake1,
    input  logic                        allocWake2,
    input  logic                        grantValid,
    input  logic [rsPkg::idxWidth-1:0]  grantIdx,
    output logic [rsPkg::tagWidth-1:0]  src1Tags [rsPkg::rsDepth],
    output logic [rsPkg::tagWidth-1:0]  src2Tags [rsPkg::rsDepth],
    output logic [rsPkg::rsDepth-1:0]   occupiedVec,
    output logic [rsPkg::rsDepth-1:0]   readyVec,
    output rsPkg::rsOpT                 grantOp
);
    import rsPkg::*;

    rsOpT               ops [rsDepth];
    logic [rsDepth-1:0] ready1;
    logic [rsDepth-1:0] ready2;

    always_ff @(posedge clk) begin
        if (allocFire) begin
            ops[tail] <= alloc.op;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN || exception) begin
            occupiedVec <= '0;
            ready1      <= '0;
            ready2      <= '0;
        end else begin
            // stale tags in free slots must not wake anything
            for (int i = 0; i < rsDepth; i++) begin
                if (occupiedVec[i] && wake1Vec[i]) begin
                    ready1[i] <= 1'b1;
                end
                if (occupiedVec[i] && wake2Vec[i]) begin
                    ready2[i] <= 1'b1;
                end
            end

            if (grantValid) begin
                occupiedVec[grantIdx] <= 1'b0;   // freed as it moves to the issue register
            end

            // tail slot is never occupied while allocation is accepted
            if (allocFire) begin
                occupiedVec[tail] <= 1'b1;
                ready1[tail]      <= alloc.src1Ready || allocWake1;
                ready2[tail]      <= alloc.src2Ready || allocWake2;
            end
        end
    end

    always_comb begin
        for (int i = 0; i < rsDepth; i++) begin
            src1Tags[i] = ops[i].src1;
            src2Tags[i] = ops[i].src2;
        end
    end

    assign readyVec = occupiedVec & ready1 & ready2;
    assign grantOp  = ops[grantIdx];

endmodule

//--- verilog/rsWakeupMatch.sv
module rsWakeupMatch (
    input  rsPkg::bcastT                 bcast    [rsPkg::numBcast],
    input  logic [rsPkg::tagWidth-1:0]   src1Tags [rsPkg::rsDepth],
    input  logic [rsPkg::tagWidth-1:0]   src2Tags [rsPkg::rsDepth],
    input  logic [rsPkg::tagWidth-1:0]   allocSrc1,
    input  logic [rsPkg::tagWidth-1:0]   allocSrc2,
    output logic [rsPkg::rsDepth-1:0]    wake1Vec,
    output logic [rsPkg::rsDepth-1:0]    wake2Vec,
    output logic                         allocWake1,
    output logic                         allocWake2
);
    import rsPkg::*;

    // true when any valid broadcast carries this tag
    function automatic logic tagHit(
        input bcastT               bc [numBcast],
        input logic [tagWidth-1:0] tag
    );
        logic hit;
        hit = 1'b0;
        for (int b = 0; b < numBcast; b++) begin
            hit |= bc[b].valid && (bc[b].tag == tag);
        end
        return hit;
    endfunction

    // occupancy and current readiness are applied in the entry array
    always_comb begin
        for (int i = 0; i < rsDepth; i++) begin
            wake1Vec[i] = tagHit(bcast, src1Tags[i]);
            wake2Vec[i] = tagHit(bcast, src2Tags[i]);
        end
    end

    // bypass for the operation being written this cycle
    always_comb begin
        allocWake1 = tagHit(bcast, allocSrc1);
        allocWake2 = tagHit(bcast, allocSrc2);
    end

endmodule

//--- verilog/rsQueuePtrs.sv
module rsQueuePtrs (
    input  logic                        clk,
    input  logic                        rstN,
    input  logic                        exception,
    input  logic                        allocValid,
    input  logic [rsPkg::rsDepth-1:0]   occupiedVec,
    output logic                        allocReady,
    output logic                        allocFire,
    output logic [rsPkg::idxWidth-1:0]  head,
    output logic [rsPkg::idxWidth-1:0]  tail
);
    import rsPkg::*;

    logic [idxWidth:0] headPtr;   // msb is the wrap bit
    logic [idxWidth:0] tailPtr;
    logic [idxWidth:0] used;
    logic              headFree;

    assign used       = tailPtr - headPtr;
    assign allocReady = (used != (idxWidth + 1)'(rsDepth));
    assign allocFire  = allocValid && allocReady;

    assign head = headPtr[idxWidth-1:0];
    assign tail = tailPtr[idxWidth-1:0];

    // slot at head was already granted, so it can be reclaimed
    assign headFree = (headPtr != tailPtr) && !occupiedVec[head];

    always_ff @(posedge clk) begin
        if (!rstN || exception) begin
            headPtr <= '0;
            tailPtr <= '0;
        end else begin
            if (allocFire) begin
                tailPtr <= tailPtr + 1'b1;
            end
            if (headFree) begin
                headPtr <= headPtr + 1'b1;   // one slot per cycle at most
            end
        end
    end

endmodule

//--- verilog/rsPkg.sv
package rsPkg;

    localparam int rsDepth    = 16;
    localparam int idxWidth   = $clog2(rsDepth);
    localparam int scanWindow = 8;                // entries examined from head for issue
    localparam int tagWidth   = 8;
    localparam int numBcast   = 4;

    typedef enum logic [3:0] {
        opAdd  = 4'd0,
        opSub  = 4'd1,
        opAnd  = 4'd2,
        opOr   = 4'd3,
        opXor  = 4'd4,
        opSll  = 4'd5,
        opSrl  = 4'd6,
        opSra  = 4'd7,
        opSlt  = 4'd8,
        opSltu = 4'd9
    } aluOpT;

    // one result broadcast from an execution unit
    typedef struct packed {
        logic                valid;
        logic [tagWidth-1:0] tag;
    } bcastT;

    typedef struct packed {
        logic [31:0]         instNum;
        logic [tagWidth-1:0] rd;
        logic                memToReg;
        logic                memRead;
        logic                memWrite;
        aluOpT               aluOp;
        logic                aluSrc2;
        logic [2:0]          funct3;
        logic [31:0]         imm;
        logic [tagWidth-1:0] src1;
        logic [tagWidth-1:0] src2;
    } rsOpT;

    // readiness as known at rename time
    typedef struct packed {
        rsOpT op;
        logic src1Ready;
        logic src2Ready;
    } rsAllocT;

endpackage
